/* Bender.yml */
package:
  name: conv3x3_core

sources:
  - files:
      - src/conv_pkg.sv
      - src/kernel_fifo.sv
      - src/kernel_weight_buffer.sv
      - src/window_builder.sv
      - src/conv_mac.sv
      - src/conv3x3_core.sv
  - target: test
    files:
      - tests/conv3x3_core_chk.sv
      - tests/tb_conv3x3_core.sv

/* build.f */
src/conv_pkg.sv
src/kernel_fifo.sv
src/kernel_weight_buffer.sv
src/window_builder.sv
src/conv_mac.sv
src/conv3x3_core.sv
tests/conv3x3_core_chk.sv
tests/tb_conv3x3_core.sv

/* src/conv3x3_core.sv */
module conv3x3_core #(
	parameter int IMG_WIDTH    = 8,
	parameter int KERNEL_DEPTH = 4
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              weight_valid,
	input  conv_pkg::weight_t weight,
	input  logic              load_weights,
	input  logic              pixel_valid,
	input  logic              sof,
	input  conv_pkg::pixel_t  pixel,
	output logic              kernel_valid,
	output logic              kernel_full,
	output conv_pkg::acc_t    result,
	output logic              result_valid
);
	import conv_pkg::*;

	kernel_t active_kernel;
	window_t window;
	logic    window_valid;

	kernel_weight_buffer #(
		.KERNEL_DEPTH(KERNEL_DEPTH)
	) u_weight_buffer (
		.clk          (clk),
		.reset        (reset),
		.weight_valid (weight_valid),
		.weight       (weight),
		.load_weights (load_weights),
		.active_kernel(active_kernel),
		.kernel_valid (kernel_valid),
		.kernel_full  (kernel_full)
	);

	window_builder #(
		.IMG_WIDTH(IMG_WIDTH)
	) u_window_builder (
		.clk         (clk),
		.reset       (reset),
		.pixel_valid (pixel_valid),
		.sof         (sof),
		.pixel       (pixel),
		.window      (window),
		.window_valid(window_valid)
	);

	// Multiplies with whatever kernel is currently active
	conv_mac u_conv_mac (
		.clk         (clk),
		.reset       (reset),
		.kernel      (active_kernel),
		.window      (window),
		.window_valid(window_valid),
		.result      (result),
		.result_valid(result_valid)
	);

endmodule

/* src/conv_mac.sv */
module conv_mac (
	input  logic              clk,
	input  logic              reset,
	input  conv_pkg::kernel_t kernel,
	input  conv_pkg::window_t window,
	input  logic              window_valid,
	output conv_pkg::acc_t    result,
	output logic              result_valid
);
	import conv_pkg::*;

	localparam int PROD_W = 2 * DATA_WIDTH;

	logic signed [PROD_W-1:0] prod_q [TAPS];
	acc_t                     ext [TAPS];
	acc_t                     pair_sum [4];
	acc_t                     quad_sum [2];
	acc_t                     tree_sum;
	logic [1:0]               vld_q;

	////////////////////////////////////////
	// Stage one
	always_ff @(posedge clk) begin
		for (int i = 0; i < TAPS; i++) begin
			prod_q[i] <= kernel.tap[i] * window.tap[i];
		end
	end

	////////////////////////////////////////
	// Stage two
	always_comb begin
		for (int i = 0; i < TAPS; i++) begin
			ext[i] = prod_q[i];
		end
		for (int j = 0; j < 4; j++) begin
			pair_sum[j] = ext[2*j] + ext[2*j+1];
		end
		quad_sum[0] = pair_sum[0] + pair_sum[1];
		quad_sum[1] = pair_sum[2] + pair_sum[3];
		// Odd tap joins at the last level
		tree_sum = quad_sum[0] + quad_sum[1] + ext[TAPS-1];
	end

	always_ff @(posedge clk) begin
		result <= tree_sum;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			vld_q <= 2'b00;
		end else begin
			vld_q <= {vld_q[0], window_valid};
		end
	end

	assign result_valid = vld_q[1];

endmodule

/* src/conv_pkg.sv */
package conv_pkg;

	localparam int DATA_WIDTH = 16;
	// Room for nine full-width products
	localparam int ACC_WIDTH  = 36;
	localparam int TAPS       = 9;

	typedef logic signed [DATA_WIDTH-1:0] pixel_t;
	typedef logic signed [DATA_WIDTH-1:0] weight_t;
	typedef logic signed [ACC_WIDTH-1:0]  acc_t;

	// Row-major taps with tap 0 at the top left
	typedef struct packed {
		weight_t [0:TAPS-1] tap;
	} kernel_t;

	// Same tap order as the kernel
	typedef struct packed {
		pixel_t [0:TAPS-1] tap;
	} window_t;

endpackage

/* src/kernel_fifo.sv */
module kernel_fifo #(
	parameter int KERNEL_DEPTH = 4
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              wr_en,
	input  logic              rd_en,
	input  conv_pkg::kernel_t din,
	output conv_pkg::kernel_t dout,
	output logic              full,
	output logic              empty
);
	import conv_pkg::*;

	localparam int PTR_W = $clog2(KERNEL_DEPTH);
	localparam int CNT_W = $clog2(KERNEL_DEPTH + 1);

	kernel_t          mem [KERNEL_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;
	logic             wr_ok;
	logic             rd_ok;

	// Overflow and underflow are dropped here
	assign wr_ok = wr_en && !full;
	assign rd_ok = rd_en && !empty;

	always_comb begin
		count_next = count;
		if (wr_ok && !rd_ok) begin
			count_next = count + 1'b1;
		end else if (rd_ok && !wr_ok) begin
			count_next = count - 1'b1;
		end
	end

	// Pointers wrap on their own for a power-of-two depth
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			full   <= 1'b0;
			empty  <= 1'b1;
		end else begin
			if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count_next;
			full  <= (count_next == CNT_W'(KERNEL_DEPTH));
			empty <= (count_next == '0);
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= din;
		end
		if (rd_ok) begin
			dout <= mem[rd_ptr];
		end
	end

endmodule

/* src/kernel_weight_buffer.sv */
module kernel_weight_buffer #(
	parameter int KERNEL_DEPTH = 4
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              weight_valid,
	input  conv_pkg::weight_t weight,
	input  logic              load_weights,
	output conv_pkg::kernel_t active_kernel,
	output logic              kernel_valid,
	output logic              kernel_full
);
	import conv_pkg::*;

	localparam int GRP_W = $clog2(TAPS);

	kernel_t          shift_k;
	kernel_t          fifo_dout;
	logic [GRP_W-1:0] grp_cnt;
	logic             wr_pulse;
	logic             fifo_empty;
	logic             load_done;

	////////////////////////////////////////
	// Weight shift chain
	// New weights enter at tap 8 and move toward tap 0
	always_ff @(posedge clk) begin
		if (weight_valid) begin
			for (int i = 0; i < TAPS - 1; i++) begin
				shift_k.tap[i] <= shift_k.tap[i+1];
			end
			shift_k.tap[TAPS-1] <= weight;
		end
	end

	// Modulo-9 group count
	always_ff @(posedge clk) begin
		if (reset) begin
			grp_cnt  <= '0;
			wr_pulse <= 1'b0;
		end else begin
			wr_pulse <= 1'b0;
			if (weight_valid) begin
				if (grp_cnt == GRP_W'(TAPS - 1)) begin
					grp_cnt  <= '0;
					wr_pulse <= 1'b1;
				end else begin
					grp_cnt <= grp_cnt + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////
	// Kernel queue
	kernel_fifo #(
		.KERNEL_DEPTH(KERNEL_DEPTH)
	) u_kernel_fifo (
		.clk  (clk),
		.reset(reset),
		.wr_en(wr_pulse),
		.rd_en(load_weights),
		.din  (shift_k),
		.dout (fifo_dout),
		.full (kernel_full),
		.empty(fifo_empty)
	);

	// FIFO output is valid one cycle after an accepted pop
	always_ff @(posedge clk) begin
		if (reset) begin
			load_done    <= 1'b0;
			kernel_valid <= 1'b0;
		end else begin
			load_done <= load_weights && !fifo_empty;
			if (load_done) begin
				kernel_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_done) begin
			active_kernel <= fifo_dout;
		end
	end

endmodule

/* src/window_builder.sv */
module window_builder #(
	parameter int IMG_WIDTH = 8
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              pixel_valid,
	input  logic              sof,
	input  conv_pkg::pixel_t  pixel,
	output conv_pkg::window_t window,
	output logic              window_valid
);
	import conv_pkg::*;

	localparam int COL_W = $clog2(IMG_WIDTH);

	// Previous row and the row before it
	pixel_t           line_mid [IMG_WIDTH];
	pixel_t           line_top [IMG_WIDTH];
	pixel_t           mid_px;
	pixel_t           top_px;
	logic [COL_W-1:0] col;
	logic [COL_W-1:0] cur_col;
	logic [1:0]       row;
	logic [1:0]       cur_row;

	// Start of frame puts this pixel at column 0 of row 0
	assign cur_col = sof ? '0 : col;
	assign cur_row = sof ? 2'd0 : row;

	assign top_px = line_top[cur_col];
	assign mid_px = line_mid[cur_col];

	////////////////////////////////////////
	// Line memories
	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			line_top[cur_col] <= mid_px;
			line_mid[cur_col] <= pixel;
		end
	end

	// Shift the window left, newest column enters on the right
	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			for (int r = 0; r < 3; r++) begin
				window.tap[3*r]   <= window.tap[3*r+1];
				window.tap[3*r+1] <= window.tap[3*r+2];
			end
			window.tap[2] <= top_px;
			window.tap[5] <= mid_px;
			window.tap[8] <= pixel;
		end
	end

	////////////////////////////////////////
	// Position counters
	always_ff @(posedge clk) begin
		if (reset) begin
			col          <= '0;
			row          <= 2'd0;
			window_valid <= 1'b0;
		end else begin
			window_valid <= pixel_valid && (cur_col >= 2) && (cur_row == 2'd2);
			if (pixel_valid) begin
				if (cur_col == COL_W'(IMG_WIDTH - 1)) begin
					col <= '0;
					// Row saturates at 2
					row <= (cur_row == 2'd2) ? cur_row : cur_row + 1'b1;
				end else begin
					col <= cur_col + 1'b1;
					row <= cur_row;
				end
			end else if (sof) begin
				col <= '0;
				row <= 2'd0;
			end
		end
	end

endmodule

/* tests/conv3x3_core_chk.sv */
module conv3x3_core_chk (
	input logic clk,
	input logic reset,
	input logic load_weights,
	input logic kernel_valid,
	input logic kernel_full,
	input logic result_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// MAC pipeline is empty right after reset
	assert property (@(posedge clk) $fell(reset) |-> !result_valid [*3]) else begin
		$error("result_valid high within three cycles of reset release");
		fail_count++;
	end

	// Kernel stays valid once loaded
	assert property (@(posedge clk) disable iff (reset) kernel_valid |=> kernel_valid) else begin
		$error("kernel_valid fell without reset");
		fail_count++;
	end

	// Only a load clears full, so a dropped kernel write leaves it set
	assert property (@(posedge clk) disable iff (reset)
		kernel_full && !load_weights |=> kernel_full) else begin
		$error("kernel_full fell without a load");
		fail_count++;
	end

endmodule

bind conv3x3_core conv3x3_core_chk u_chk (.*);

/* tests/tb_conv3x3_core.sv */
module tb_conv3x3_core;
	timeunit 1ns;
	timeprecision 1ps;
	import conv_pkg::*;

	localparam int IMG_WIDTH = 8;
	localparam int ROWS      = 5;
	localparam int DEPTH     = 4;
	localparam int TIMEOUT   = 200;

	logic        clk = 1'b0;
	logic        reset, weight_valid, load_weights, pixel_valid, sof;
	weight_t     weight;
	pixel_t      pixel;
	logic        kernel_valid, kernel_full, result_valid;
	acc_t        result;
	logic [31:0] rng = 32'ha8f0;
	int          errors = 0;
	int          checks = 0;
	int          cyc = 0;
	int          active_id = 0;
	int          next_id = 0;
	int          queued [$];
	weight_t     kern_ref [8][TAPS];
	acc_t        exp_res [$];
	acc_t        got_res [$];
	int          exp_edge [$];
	int          got_edge [$];

	conv3x3_core #(.IMG_WIDTH(IMG_WIDTH), .KERNEL_DEPTH(DEPTH)) DUT (.*);

	always #10 clk = ~clk;

	// After rising edge n this holds n
	always @(posedge clk) cyc <= cyc + 1;

	always @(negedge clk) begin
		if (!reset && result_valid) begin
			got_res.push_back(result);
			got_edge.push_back(cyc);
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// Signed sample in -128..127
	function automatic logic signed [15:0] small_rand();
		rng = xorshift32(rng);
		return {{8{rng[7]}}, rng[7:0]};
	endfunction

	task automatic check_equal(input string name, input logic [ACC_WIDTH-1:0] got, exp);
		checks++;
		assert (got === exp) else begin
			$display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	////////////////////////////////////////
	// Stimulus and reference model
	task automatic send_kernel();
		for (int k = 0; k < TAPS; k++) begin
			kern_ref[next_id][k] = small_rand();
			@(posedge clk);
			weight_valid <= 1'b1;
			weight       <= kern_ref[next_id][k];
		end
		@(posedge clk);
		weight_valid <= 1'b0;
		// Queue write lands one edge after the ninth weight is taken
		repeat (2) @(posedge clk);
		if (queued.size() < DEPTH) begin
			queued.push_back(next_id);
		end
		next_id++;
	endtask

	task automatic pulse_load();
		@(posedge clk);
		load_weights <= 1'b1;
		@(posedge clk);
		load_weights <= 1'b0;
		if (queued.size() > 0) begin
			active_id = queued.pop_front();
		end
	endtask

	task automatic run_frame();
		pixel_t px [ROWS][IMG_WIDTH];
		acc_t   sum;
		for (int r = 0; r < ROWS; r++) begin
			for (int c = 0; c < IMG_WIDTH; c++) begin
				px[r][c] = small_rand();
				@(posedge clk);
				pixel_valid <= 1'b1;
				sof         <= (r == 0 && c == 0);
				pixel       <= px[r][c];
				if (r >= 2 && c >= 2) begin
					sum = '0;
					// Row-major taps, first weight on the top-left pixel
					for (int i = 0; i < TAPS; i++) begin
						sum += px[r-2+i/3][c-2+i%3] * kern_ref[active_id][i];
					end
					exp_res.push_back(sum);
					// Driven at edge cyc+1, result registered three edges later
					exp_edge.push_back(cyc + 4);
				end
			end
		end
		@(posedge clk);
		pixel_valid <= 1'b0;
		sof         <= 1'b0;
	endtask

	task automatic check_frame();
		int waited = 0;
		while (got_res.size() < exp_res.size() && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (got_res.size() < exp_res.size()) begin
			$display("Timed out waiting for result_valid after %0d results", got_res.size());
			errors++;
		end
		repeat (4) @(negedge clk);
		check_equal("result count", got_res.size(), (IMG_WIDTH - 2) * (ROWS - 2));
		for (int i = 0; i < got_res.size() && i < exp_res.size(); i++) begin
			check_equal("result", got_res[i], exp_res[i]);
			check_equal("result_valid edge", got_edge[i], exp_edge[i]);
		end
		exp_res.delete();
		exp_edge.delete();
		got_res.delete();
		got_edge.delete();
	endtask

	////////////////////////////////////////
	// Directed tests
	task automatic test_kernel_load();
		int waited = 0;
		check_equal("kernel_valid", kernel_valid, 0);
		send_kernel();
		pulse_load();
		@(negedge clk);
		check_equal("kernel_valid", kernel_valid, 0);
		while (!kernel_valid && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!kernel_valid) begin
			$display("Timed out waiting for kernel_valid");
			errors++;
		end
		check_equal("kernel_valid delay", waited, 1);
	endtask

	// Also covers back-to-back windows through the edge checks
	task automatic test_single_frame();
		run_frame();
		check_frame();
	endtask

	task automatic test_kernel_order();
		send_kernel();
		send_kernel();
		pulse_load();
		run_frame();
		check_frame();
		pulse_load();
		run_frame();
		check_frame();
	endtask

	task automatic test_empty_load();
		pulse_load();
		run_frame();
		check_frame();
		check_equal("kernel_valid", kernel_valid, 1);
	endtask

	task automatic test_full_drop();
		for (int k = 0; k < DEPTH + 1; k++) begin
			send_kernel();
			@(negedge clk);
			check_equal("kernel_full", kernel_full, queued.size() == DEPTH);
		end
		for (int k = 0; k < DEPTH; k++) begin
			pulse_load();
			run_frame();
			check_frame();
		end
		check_equal("kernel_full", kernel_full, 0);
	endtask

	initial begin
		reset        = 1'b1;
		weight_valid = 1'b0;
		weight       = '0;
		load_weights = 1'b0;
		pixel_valid  = 1'b0;
		sof          = 1'b0;
		pixel        = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		test_kernel_load();
		test_single_frame();
		test_kernel_order();
		test_empty_load();
		test_full_drop();
		repeat (5) @(posedge clk);
		// Failures of the bound assertions
		errors += DUT.u_chk.fail_count;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
